// ==== flist.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_mem_if.sv
rtl/rv_reg_file.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
rtl/rv_top.sv
tb/tb_clk_gen.sv
tb/rv_properties.sv
tb/tb_rv_top.sv

// ==== rtl/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data path and register width.
`define RV_XLEN 64

// Instruction width.
`define RV_ILEN 32

`define RV_REG_ADDR_W 5

`define RV_RESET_PC 64'h0000_0000_0000_0000

`endif

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`RV_ILEN-1:0]       instr,
  output logic [`RV_XLEN-1:0]       pc,
  output logic                      error,
  output logic                      done,
  rv_mem_if.core                    mem,
  output logic [`RV_REG_ADDR_W-1:0] rs1_addr,
  output logic [`RV_REG_ADDR_W-1:0] rs2_addr,
  input  logic [`RV_XLEN-1:0]       rs1_data,
  input  logic [`RV_XLEN-1:0]       rs2_data,
  output logic [`RV_REG_ADDR_W-1:0] rd_addr,
  output logic [`RV_XLEN-1:0]       rd_data,
  output logic                      rd_we
);

  localparam logic [`RV_ILEN-1:0] EBREAK = 32'h0010_0073;

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                halted;
  logic                legal;
  logic                is_ebreak;
  logic                writes_rd;
  logic                is_load;
  logic                is_store;
  logic                is_sub;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;

  assign opcode   = rv_pkg::opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];

  assign halted = done | error;

  // Anything outside the supported subset leaves legal low.
  always_comb begin
    legal     = 1'b0;
    is_ebreak = 1'b0;
    writes_rd = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_sub    = 1'b0;
    imm       = '0;
    case (opcode)
      rv_pkg::OP_LUI: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        imm       = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'h000};
      end
      rv_pkg::OP_IMM: begin
        legal     = (funct3 == 3'b000);
        writes_rd = 1'b1;
        imm       = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
      end
      rv_pkg::OP_REG: begin
        legal     = (funct3 == 3'b000) && ((funct7 == 7'h00) || (funct7 == 7'h20));
        writes_rd = 1'b1;
        is_sub    = funct7[5];
      end
      rv_pkg::OP_LOAD: begin
        legal     = (funct3 != 3'b111);
        writes_rd = 1'b1;
        is_load   = 1'b1;
        imm       = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
      end
      rv_pkg::OP_STORE: begin
        legal    = !funct3[2];
        is_store = 1'b1;
        imm      = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
      end
      rv_pkg::OP_SYSTEM: begin
        is_ebreak = (instr == EBREAK);
        legal     = is_ebreak;
      end
      default: ;
    endcase
  end

  // lui adds its immediate to zero, loads and stores form rs1 plus offset.
  assign op_a    = (opcode == rv_pkg::OP_LUI) ? '0 : rs1_data;
  assign op_b    = (opcode == rv_pkg::OP_REG) ? rs2_data : imm;
  assign alu_res = is_sub ? (op_a - op_b) : (op_a + op_b);

  assign mem.addr   = alu_res;
  assign mem.mem_op = rv_pkg::mem_op_e'(funct3);
  assign mem.wdata  = rs2_data;
  assign mem.rd_en  = !halted && legal && is_load;
  assign mem.wr_en  = !halted && legal && is_store;

  assign rd_data = is_load ? mem.rdata : alu_res;
  assign rd_we   = !halted && legal && writes_rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc    <= `RV_RESET_PC;
      done  <= 1'b0;
      error <= 1'b0;
    end else if (!halted) begin
      pc <= pc + `RV_XLEN'(4);
      if (is_ebreak) begin
        done <= 1'b1;
      end
      if (!legal) begin
        error <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/rv_lsu.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_lsu (
  rv_mem_if.lsu               bus,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic                mem_rd,
  output logic                mem_wr,
  output logic [`RV_XLEN-1:0] mem_wdata,
  input  logic [`RV_XLEN-1:0] mem_rdata
);

  localparam int NUM_BYTES = `RV_XLEN / 8;

  logic [2:0]           offset;
  logic [7:0]           byte_lane;
  logic [15:0]          half_lane;
  logic [31:0]          word_lane;
  logic [NUM_BYTES-1:0] byte_mask;
  logic [`RV_XLEN-1:0]  store_repl;

  assign mem_addr = bus.addr;
  assign mem_rd   = bus.rd_en;
  assign mem_wr   = bus.wr_en;

  // The low address bits pick the lane inside the doubleword.
  assign offset = bus.addr[2:0];

  // Each lane sits on its natural boundary, so the low bits below the
  // access size are ignored.
  assign byte_lane = mem_rdata[{offset, 3'b000} +: 8];
  assign half_lane = mem_rdata[{offset[2:1], 4'b0000} +: 16];
  assign word_lane = mem_rdata[{offset[2], 5'b00000} +: 32];

  always_comb begin
    case (bus.mem_op)
      rv_pkg::MEM_B:  bus.rdata = {{(`RV_XLEN-8){byte_lane[7]}}, byte_lane};
      rv_pkg::MEM_BU: bus.rdata = {{(`RV_XLEN-8){1'b0}}, byte_lane};
      rv_pkg::MEM_H:  bus.rdata = {{(`RV_XLEN-16){half_lane[15]}}, half_lane};
      rv_pkg::MEM_HU: bus.rdata = {{(`RV_XLEN-16){1'b0}}, half_lane};
      rv_pkg::MEM_W:  bus.rdata = {{(`RV_XLEN-32){word_lane[31]}}, word_lane};
      rv_pkg::MEM_WU: bus.rdata = {{(`RV_XLEN-32){1'b0}}, word_lane};
      default:        bus.rdata = mem_rdata;
    endcase
  end

  // Store value is replicated across all lanes so that whichever lane the
  // mask selects already holds the right bytes.
  always_comb begin
    case (bus.mem_op)
      rv_pkg::MEM_B: begin
        byte_mask  = NUM_BYTES'(8'b0000_0001) << offset;
        store_repl = {NUM_BYTES{bus.wdata[7:0]}};
      end
      rv_pkg::MEM_H: begin
        byte_mask  = NUM_BYTES'(8'b0000_0011) << {offset[2:1], 1'b0};
        store_repl = {(NUM_BYTES / 2){bus.wdata[15:0]}};
      end
      rv_pkg::MEM_W: begin
        byte_mask  = NUM_BYTES'(8'b0000_1111) << {offset[2], 2'b00};
        store_repl = {(NUM_BYTES / 4){bus.wdata[31:0]}};
      end
      default: begin
        byte_mask  = '1;
        store_repl = bus.wdata;
      end
    endcase
  end

  // Unmasked bytes keep the old doubleword read back from memory.
  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      mem_wdata[i*8 +: 8] = byte_mask[i] ? store_repl[i*8 +: 8] : mem_rdata[i*8 +: 8];
    end
  end

endmodule

// ==== rtl/rv_mem_if.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

// One data access per cycle between the core and the load-store unit.
// The access completes combinationally in the cycle it is presented.
interface rv_mem_if;

  logic [`RV_XLEN-1:0] addr;
  rv_pkg::mem_op_e     mem_op;
  logic                rd_en;
  logic                wr_en;
  logic [`RV_XLEN-1:0] wdata;
  logic [`RV_XLEN-1:0] rdata;

  modport core (
    output addr, mem_op, rd_en, wr_en, wdata,
    input  rdata
  );

  modport lsu (
    input  addr, mem_op, rd_en, wr_en, wdata,
    output rdata
  );

endinterface

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  // Major opcodes of the supported RV64I subset.
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // Access size and signedness, encoded exactly as funct3 of loads and stores.
  // Stores only ever use the signed encodings.
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

endpackage

// ==== rtl/rv_reg_file.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_reg_file (
  input  logic                      clk,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
  input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data,
  input  logic [`RV_REG_ADDR_W-1:0] rd_addr,
  input  logic [`RV_XLEN-1:0]       rd_data,
  input  logic                      rd_we,
  input  logic [`RV_REG_ADDR_W-1:0] dbg_addr,
  output logic [`RV_XLEN-1:0]       dbg_data,
  output logic                      a0_bit
);

  localparam int NUM_REGS = 1 << `RV_REG_ADDR_W;

  logic [`RV_XLEN-1:0] regs [NUM_REGS];

  // Entry 0 is never written, its reads are forced to zero instead.
  function automatic logic [`RV_XLEN-1:0] read_reg(input logic [`RV_REG_ADDR_W-1:0] idx);
    return (idx == '0) ? '0 : regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rd_we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = read_reg(rs1_addr);
  assign rs2_data = read_reg(rs2_addr);
  assign dbg_data = read_reg(dbg_addr);

  // x10 (a0) carries the program status bit.
  assign a0_bit = regs[10][0];

endmodule

// ==== rtl/rv_top.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`RV_XLEN-1:0]       instr_data,
  output logic [`RV_XLEN-1:0]       pc,
  output logic [`RV_XLEN-1:0]       addr,
  output logic [`RV_XLEN-1:0]       data_wr_data,
  input  logic [`RV_XLEN-1:0]       data_rd_data,
  output logic                      mem_rd,
  output logic                      mem_wr,
  output logic                      error,
  output logic                      done,
  output logic                      status,
  input  logic [`RV_REG_ADDR_W-1:0] dbg_addr,
  output logic [`RV_XLEN-1:0]       dbg_data
);

  logic [`RV_ILEN-1:0]        instr;
  logic [`RV_REG_ADDR_W-1:0]  rs1_addr;
  logic [`RV_REG_ADDR_W-1:0]  rs2_addr;
  logic [`RV_REG_ADDR_W-1:0]  rd_addr;
  logic [`RV_XLEN-1:0]        rs1_data;
  logic [`RV_XLEN-1:0]        rs2_data;
  logic [`RV_XLEN-1:0]        rd_data;
  logic                       rd_we;

  rv_mem_if mem_bus ();

  // Two instructions share a fetch doubleword, pc bit 2 picks the half.
  assign instr = pc[2] ? instr_data[`RV_XLEN-1:`RV_ILEN] : instr_data[`RV_ILEN-1:0];

  rv_core i_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .instr    (instr),
    .pc       (pc),
    .error    (error),
    .done     (done),
    .mem      (mem_bus.core),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_we    (rd_we)
  );

  rv_reg_file i_reg_file (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_we    (rd_we),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data),
    .a0_bit   (status)
  );

  rv_lsu i_lsu (
    .bus       (mem_bus.lsu),
    .mem_addr  (addr),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_wdata (data_wr_data),
    .mem_rdata (data_rd_data)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_top -f flist.f -Mdir obj_dir -o sim_tb_rv_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_rv_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// ==== tb/rv_properties.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_properties (
  input logic                clk,
  input logic                rst_n,
  input logic [`RV_XLEN-1:0] pc,
  input logic                mem_rd,
  input logic                mem_wr,
  input logic                done,
  input logic                error
);

  int failures = 0;

  assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr))
    else begin
      $error("mem_rd and mem_wr are high in the same cycle");
      failures++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) done |=> done)
    else begin
      $error("done dropped without a reset");
      failures++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) error |=> error)
    else begin
      $error("error dropped without a reset");
      failures++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) (done || error) |=> $stable(pc))
    else begin
      $error("pc moved while the core is halted");
      failures++;
    end

  // A running core retires exactly one instruction per cycle.
  assert property (@(posedge clk) disable iff (!rst_n)
                   !(done || error) |=> (pc == $past(pc) + `RV_XLEN'(4)))
    else begin
      $error("pc did not advance by 4");
      failures++;
    end

endmodule

bind rv_top rv_properties i_rv_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .pc     (pc),
  .mem_rd (mem_rd),
  .mem_wr (mem_wr),
  .done   (done),
  .error  (error)
);

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

// Free-running clock with a 100 ns period.
module tb_clk_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== tb/tb_rv_top.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module tb_rv_top;

  localparam logic [6:0]  OPC_IMM   = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD  = 7'b0000011;
  localparam logic [31:0] EBREAK    = 32'h0010_0073;
  // Opcode zero is illegal, so fetching the wrong half raises error.
  localparam logic [31:0] FILL_WORD = 32'h0000_0000;
  localparam logic [1:0]  HALT_NONE = 2'b00;
  localparam logic [1:0]  HALT_DONE = 2'b01;
  localparam logic [1:0]  HALT_ERR  = 2'b10;
  localparam logic [1:0]  ACC_NONE  = 2'b00;
  localparam logic [1:0]  ACC_WR    = 2'b01;
  localparam logic [1:0]  ACC_RD    = 2'b10;

  logic                      clk;
  logic                      rst_n;
  logic [`RV_XLEN-1:0]       instr_data;
  logic [`RV_XLEN-1:0]       pc;
  logic [`RV_XLEN-1:0]       addr;
  logic [`RV_XLEN-1:0]       data_wr_data;
  logic [`RV_XLEN-1:0]       data_rd_data;
  logic                      mem_rd;
  logic                      mem_wr;
  logic                      error;
  logic                      done;
  logic                      status;
  logic [`RV_REG_ADDR_W-1:0] dbg_addr;
  logic [`RV_XLEN-1:0]       dbg_data;

  logic [`RV_XLEN-1:0] mem [16];

  // Each row holds an instruction, the register to read back with its value, a memory
  // doubleword index (negative for none) with its value, {error, done}, and the
  // expected {mem_rd, mem_wr} with the access address.
  logic [31:0]               tbl_instr [$];
  logic [`RV_REG_ADDR_W-1:0] tbl_rd [$];
  logic [`RV_XLEN-1:0]       tbl_rval [$];
  int                        tbl_midx [$];
  logic [`RV_XLEN-1:0]       tbl_mval [$];
  logic [1:0]                tbl_halt [$];
  logic [1:0]                tbl_acc [$];
  logic [`RV_XLEN-1:0]       tbl_addr [$];

  int                  second_run;
  int                  errors;
  logic [`RV_XLEN-1:0] exp_pc;
  logic                halted_model;
  logic                status_known;
  logic                exp_status;
  logic                timed_out;

  tb_clk_gen i_clk_gen (.clk(clk));

  rv_top i_rv_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_data   (instr_data),
    .pc           (pc),
    .addr         (addr),
    .data_wr_data (data_wr_data),
    .data_rd_data (data_rd_data),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .error        (error),
    .done         (done),
    .status       (status),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
  );

  function automatic logic [7:0] pattern_byte(input int a);
    return 8'h80 | 8'(a);
  endfunction

  function automatic logic [`RV_XLEN-1:0] fill_dword(input int idx);
    logic [`RV_XLEN-1:0] d;
    d = '0;
    for (int j = 7; j >= 0; j--) begin
      d = {d[`RV_XLEN-9:0], pattern_byte(idx * 8 + j)};
    end
    return d;
  endfunction

  function automatic logic [31:0] encode_itype(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_stype(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Combinational read, write captured at the edge, pattern reloaded in reset.
  assign data_rd_data = mem[addr[6:3]];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        mem[4'(i)] <= fill_dword(i);
      end
    end else if (mem_wr) begin
      mem[addr[6:3]] <= data_wr_data;
    end
  end

  task automatic add_row(input logic [31:0] ins, input logic [4:0] rd,
                         input logic [`RV_XLEN-1:0] rval, input int midx,
                         input logic [`RV_XLEN-1:0] mval, input logic [1:0] halt,
                         input logic [1:0] acc = ACC_NONE,
                         input logic [`RV_XLEN-1:0] acc_addr = '0);
    tbl_instr.push_back(ins);
    tbl_rd.push_back(rd);
    tbl_rval.push_back(rval);
    tbl_midx.push_back(midx);
    tbl_mval.push_back(mval);
    tbl_halt.push_back(halt);
    tbl_acc.push_back(acc);
    tbl_addr.push_back(acc_addr);
  endtask

  task automatic build_table();
    int          a;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    add_row(encode_lui(20'h12345, 5'd1), 5'd1, 64'h1234_5000, -1, '0, HALT_NONE);
    add_row(encode_itype(12'h678, 5'd1, 3'b000, 5'd1, OPC_IMM), 5'd1, 64'h1234_5678, -1, '0,
            HALT_NONE);
    add_row(encode_itype(12'hfff, 5'd0, 3'b000, 5'd2, OPC_IMM), 5'd2, '1, -1, '0, HALT_NONE);
    add_row(encode_rtype(7'h00, 5'd2, 5'd1, 5'd3), 5'd3, 64'h1234_5677, -1, '0, HALT_NONE);
    add_row(encode_rtype(7'h20, 5'd2, 5'd1, 5'd4), 5'd4, 64'h1234_5679, -1, '0, HALT_NONE);
    add_row(encode_itype(12'd5, 5'd1, 3'b000, 5'd0, OPC_IMM), 5'd0, '0, -1, '0, HALT_NONE);
    add_row(encode_lui(20'h80000, 5'd5), 5'd5, 64'hffff_ffff_8000_0000, -1, '0, HALT_NONE);
    add_row(encode_itype(12'd1, 5'd0, 3'b000, 5'd10, OPC_IMM), 5'd10, 64'd1, -1, '0, HALT_NONE);
    add_row(encode_itype(12'd2, 5'd0, 3'b000, 5'd10, OPC_IMM), 5'd10, 64'd2, -1, '0, HALT_NONE);
    add_row(encode_itype(12'd16, 5'd0, 3'b000, 5'd6, OPC_IMM), 5'd6, 64'd16, -1, '0, HALT_NONE);
    // Loads from doubleword 2, whose bytes all have their top bit set.
    for (int k = 0; k < 8; k++) begin
      a = 16 + k;
      b = pattern_byte(a);
      add_row(encode_itype(12'(k), 5'd6, 3'b000, 5'd7, OPC_LOAD), 5'd7, {{56{b[7]}}, b}, -1,
              '0, HALT_NONE, ACC_RD, 64'(a));
      add_row(encode_itype(12'(k), 5'd6, 3'b100, 5'd7, OPC_LOAD), 5'd7, {56'h0, b}, -1, '0,
              HALT_NONE, ACC_RD, 64'(a));
    end
    for (int k = 0; k < 8; k += 2) begin
      a = 16 + k;
      h = {pattern_byte(a + 1), pattern_byte(a)};
      add_row(encode_itype(12'(k), 5'd6, 3'b001, 5'd7, OPC_LOAD), 5'd7, {{48{h[15]}}, h}, -1,
              '0, HALT_NONE, ACC_RD, 64'(a));
      add_row(encode_itype(12'(k), 5'd6, 3'b101, 5'd7, OPC_LOAD), 5'd7, {48'h0, h}, -1, '0,
              HALT_NONE, ACC_RD, 64'(a));
    end
    for (int k = 0; k < 8; k += 4) begin
      a = 16 + k;
      w = {pattern_byte(a + 3), pattern_byte(a + 2), pattern_byte(a + 1), pattern_byte(a)};
      add_row(encode_itype(12'(k), 5'd6, 3'b010, 5'd7, OPC_LOAD), 5'd7, {{32{w[31]}}, w}, -1,
              '0, HALT_NONE, ACC_RD, 64'(a));
      add_row(encode_itype(12'(k), 5'd6, 3'b110, 5'd7, OPC_LOAD), 5'd7, {32'h0, w}, -1, '0,
              HALT_NONE, ACC_RD, 64'(a));
    end
    add_row(encode_itype(12'd0, 5'd6, 3'b011, 5'd7, OPC_LOAD), 5'd7, fill_dword(2), -1, '0,
            HALT_NONE, ACC_RD, 64'd16);
    // Stores into doublewords 3, 4 and 5; x1 holds 0x12345678.
    add_row(encode_stype(12'd9, 5'd1, 5'd6, 3'b000), 5'd1, 64'h1234_5678, 3,
            64'h9f9e_9d9c_9b9a_7898, HALT_NONE, ACC_WR, 64'd25);
    add_row(encode_stype(12'd12, 5'd1, 5'd6, 3'b001), 5'd1, 64'h1234_5678, 3,
            64'h9f9e_5678_9b9a_7898, HALT_NONE, ACC_WR, 64'd28);
    add_row(encode_stype(12'd14, 5'd1, 5'd6, 3'b001), 5'd1, 64'h1234_5678, 3,
            64'h5678_5678_9b9a_7898, HALT_NONE, ACC_WR, 64'd30);
    add_row(encode_stype(12'd16, 5'd1, 5'd6, 3'b010), 5'd1, 64'h1234_5678, 4,
            64'ha7a6_a5a4_1234_5678, HALT_NONE, ACC_WR, 64'd32);
    add_row(encode_stype(12'd20, 5'd1, 5'd6, 3'b010), 5'd1, 64'h1234_5678, 4,
            64'h1234_5678_1234_5678, HALT_NONE, ACC_WR, 64'd36);
    add_row(encode_stype(12'd24, 5'd5, 5'd6, 3'b011), 5'd1, 64'h1234_5678, 5,
            64'hffff_ffff_8000_0000, HALT_NONE, ACC_WR, 64'd40);
    add_row(EBREAK, 5'd1, 64'h1234_5678, -1, '0, HALT_DONE);
    add_row(encode_itype(12'd99, 5'd0, 3'b000, 5'd1, OPC_IMM), 5'd1, 64'h1234_5678, -1, '0,
            HALT_DONE);
    add_row(encode_stype(12'd0, 5'd5, 5'd6, 3'b011), 5'd5, 64'hffff_ffff_8000_0000, 2,
            fill_dword(2), HALT_DONE);
    second_run = tbl_instr.size();
    add_row(encode_itype(12'd7, 5'd0, 3'b000, 5'd9, OPC_IMM), 5'd9, 64'd7, -1, '0, HALT_NONE);
    add_row(32'hffff_ffff, 5'd9, 64'd7, -1, '0, HALT_ERR);
    add_row(encode_itype(12'd1, 5'd0, 3'b000, 5'd9, OPC_IMM), 5'd9, 64'd7, -1, '0, HALT_ERR);
    add_row(encode_stype(12'd0, 5'd9, 5'd0, 3'b011), 5'd9, 64'd7, 0, fill_dword(0), HALT_ERR);
  endtask

  task automatic report_mismatch(input string what, input int row,
                                 input logic [`RV_XLEN-1:0] got,
                                 input logic [`RV_XLEN-1:0] exp);
    $display("CHECK FAILED at %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
    errors++;
  endtask

  task automatic apply_reset();
    rst_n      = 1'b0;
    instr_data = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n        = 1'b1;
    exp_pc       = `RV_RESET_PC;
    halted_model = 1'b0;
    if (pc !== `RV_RESET_PC || error !== 1'b0 || done !== 1'b0 || mem_rd !== 1'b0 ||
        mem_wr !== 1'b0) begin
      $display("CHECK FAILED at %0t: after reset pc=%h error=%b done=%b mem_rd=%b mem_wr=%b",
               $time, pc, error, done, mem_rd, mem_wr);
      errors++;
    end
  endtask

  task automatic wait_halt(output logic expired);
    int cycles;
    cycles = 0;
    while (!(done || error) && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    expired = !(done || error);
    if (expired) begin
      $display("Timed out after %0d cycles waiting for done or error", cycles);
      errors++;
    end
  endtask

  // Strobes and address are looked at during the cycle, before the retiring edge.
  task automatic check_access(input int i);
    if ({mem_rd, mem_wr} !== tbl_acc[i]) begin
      report_mismatch("{mem_rd, mem_wr}", i, {62'h0, mem_rd, mem_wr}, {62'h0, tbl_acc[i]});
    end
    if (tbl_acc[i] != ACC_NONE && addr !== tbl_addr[i]) begin
      report_mismatch("addr", i, addr, tbl_addr[i]);
    end
  endtask

  task automatic check_row(input int i);
    if (pc !== exp_pc) report_mismatch("pc", i, pc, exp_pc);
    if (dbg_data !== tbl_rval[i]) report_mismatch("register", i, dbg_data, tbl_rval[i]);
    if (tbl_midx[i] >= 0 && mem[tbl_midx[i][3:0]] !== tbl_mval[i]) begin
      report_mismatch("memory", i, mem[tbl_midx[i][3:0]], tbl_mval[i]);
    end
    if ({error, done} !== tbl_halt[i]) begin
      report_mismatch("{error, done}", i, {62'h0, error, done}, {62'h0, tbl_halt[i]});
    end
    if (tbl_rd[i] == 5'd10) begin
      status_known = 1'b1;
      exp_status   = tbl_rval[i][0];
    end
    if (status_known && status !== exp_status) begin
      report_mismatch("status", i, {63'h0, status}, {63'h0, exp_status});
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    instr_data   = '0;
    dbg_addr     = '0;
    errors       = 0;
    status_known = 1'b0;
    exp_status   = 1'b0;
    timed_out    = 1'b0;
    build_table();
    for (int i = 0; i < tbl_instr.size(); i++) begin
      if (i == second_run) begin
        wait_halt(timed_out);
        if (timed_out) break;
      end
      if (i == 0 || i == second_run) apply_reset();
      instr_data = exp_pc[2] ? {tbl_instr[i], FILL_WORD} : {FILL_WORD, tbl_instr[i]};
      dbg_addr   = tbl_rd[i];
      #10;
      check_access(i);
      @(posedge clk);
      #1;
      if (!halted_model) exp_pc = exp_pc + `RV_XLEN'(4);
      halted_model = (tbl_halt[i] != HALT_NONE);
      check_row(i);
    end
    if (!timed_out) begin
      wait_halt(timed_out);
    end
    $display("Errors: %0d check errors, %0d assertion failures", errors,
             i_rv_top.i_rv_props.failures);
    if (errors == 0 && i_rv_top.i_rv_props.failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
